// ==== rtl/obi_integrity_pkg.sv ====
// Shared definitions for the data-side OBI integrity unit
// Bus field widths, checksum widths, queue sizing, cause codes
// and the transaction kind enum
package obi_integrity_pkg;

  // OBI data bus field widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int BE_W      = 4;
  localparam int PROT_W    = 3;
  localparam int MEMTYPE_W = 2;

  // Address phase checksum
  // Bits 0-3 address bytes, 4 prot/memtype, 5 be/we, 6 dbg,
  // 7 atop, 8-11 wdata bytes
  localparam int ACHK_W = 12;

  // Response checksum
  // Bits 0-3 rdata bytes, 4 err/exokay
  localparam int RCHK_W       = 5;
  localparam int RCHK_ERR_BIT = 4;

  // Transactions allowed in flight between grant and response
  localparam int OUTSTANDING_DEPTH = 2;
  localparam int OUTSTANDING_PTR_W = $clog2(OUTSTANDING_DEPTH);
  localparam int OUTSTANDING_CNT_W = $clog2(OUTSTANDING_DEPTH + 1);

  // NMI cause codes
  localparam int MCAUSE_W = 11;
  localparam logic [MCAUSE_W-1:0] CAUSE_LOAD_INTEGRITY  = 11'h402;
  localparam logic [MCAUSE_W-1:0] CAUSE_STORE_INTEGRITY = 11'h403;

  // Kind of an outstanding transaction, taken from we at grant
  typedef enum logic {
    TXN_LOAD  = 1'b0,
    TXN_STORE = 1'b1
  } txn_kind_e;

endpackage

// ==== rtl/obi_achk_gen.sv ====
// Request side of the OBI integrity unit
// Address phase checksum, request parity and back-pressure
// against the outstanding queue
`timescale 1ns/1ps

module obi_achk_gen import obi_integrity_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic [ADDR_W-1:0]    addr,
  input  logic                 we,
  input  logic [BE_W-1:0]      be,
  input  logic [DATA_W-1:0]    wdata,
  input  logic [PROT_W-1:0]    prot,
  input  logic [MEMTYPE_W-1:0] memtype,
  input  logic                 dbg,
  input  logic                 req_integrity,
  input  logic                 bus_gnt,
  input  logic                 bus_gntpar,
  input  logic                 queue_full,
  output logic                 gnt,
  output logic                 bus_req,
  output logic                 bus_reqpar,
  output logic [ACHK_W-1:0]    bus_achk,
  output logic [ADDR_W-1:0]    bus_addr,
  output logic                 bus_we,
  output logic [BE_W-1:0]      bus_be,
  output logic [DATA_W-1:0]    bus_wdata,
  output logic [PROT_W-1:0]    bus_prot,
  output logic [MEMTYPE_W-1:0] bus_memtype,
  output logic                 bus_dbg,
  output logic                 push,
  output txn_kind_e            push_kind,
  output logic                 push_integrity,
  output logic                 push_gntpar_err
);

  logic [BE_W-1:0] addr_byte_par;
  logic [BE_W-1:0] wdata_byte_par;

  // Per byte parity of address and write data
  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      addr_byte_par[i]  = ^addr[8*i +: 8];
      wdata_byte_par[i] = ^wdata[8*i +: 8];
    end
  end

  // Hold the request back while both queue entries are in use
  assign bus_req    = req & ~queue_full;
  assign bus_reqpar = ~bus_req;
  assign gnt        = bus_gnt & ~queue_full;

  // Bit 7 covers atop, which is always zero here
  assign bus_achk = {wdata_byte_par,
                     1'b0,
                     ~^dbg,
                     ~^{be, we},
                     ~^{prot, memtype},
                     addr_byte_par};

  assign bus_addr    = addr;
  assign bus_we      = we;
  assign bus_be      = be;
  assign bus_wdata   = wdata;
  assign bus_prot    = prot;
  assign bus_memtype = memtype;
  assign bus_dbg     = dbg;

  // Attributes recorded for each accepted transfer
  assign push            = bus_req & bus_gnt;
  assign push_kind       = we ? TXN_STORE : TXN_LOAD;
  assign push_integrity  = req_integrity;
  assign push_gntpar_err = (bus_gntpar == bus_gnt);

  a_no_req_rise_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    queue_full |-> !$rose(bus_req)
  ) else $error("bus_req rose while the outstanding queue was full");

endmodule

// ==== rtl/obi_outstanding_queue.sv ====
// Outstanding transaction FIFO
// Holds kind, integrity flag and grant parity error of each
// granted request until its response arrives
`timescale 1ns/1ps

module obi_outstanding_queue import obi_integrity_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n,
  input  logic      push,
  input  txn_kind_e push_kind,
  input  logic      push_integrity,
  input  logic      push_gntpar_err,
  input  logic      pop,
  output logic      full,
  output txn_kind_e head_kind,
  output logic      head_integrity,
  output logic      head_gntpar_err
);

  txn_kind_e kind_mem      [OUTSTANDING_DEPTH];
  logic      integrity_mem [OUTSTANDING_DEPTH];
  logic      gntpar_mem    [OUTSTANDING_DEPTH];

  logic [OUTSTANDING_PTR_W-1:0] wptr;
  logic [OUTSTANDING_PTR_W-1:0] rptr;
  logic [OUTSTANDING_CNT_W-1:0] count;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      kind_mem[wptr]      <= push_kind;
      integrity_mem[wptr] <= push_integrity;
      gntpar_mem[wptr]    <= push_gntpar_err;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full            = (count == OUTSTANDING_CNT_W'(OUTSTANDING_DEPTH));
  assign head_kind       = kind_mem[rptr];
  assign head_integrity  = integrity_mem[rptr];
  assign head_gntpar_err = gntpar_mem[rptr];

  // Request side must hold back while every entry is in use
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    full |-> !push
  ) else $error("Push into a full outstanding queue");

  // Every response must belong to a granted request
  a_no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    pop |-> (count != '0)
  ) else $error("Response received with no outstanding transaction");

endmodule

// ==== rtl/obi_resp_checker.sv ====
// Response side of the OBI integrity unit
// rvalid parity and rchk checks, fault reporting and the
// registered response toward the master
`timescale 1ns/1ps

module obi_resp_checker import obi_integrity_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n,
  input  logic              bus_gnt,
  input  logic              bus_gntpar,
  input  logic              bus_rvalid,
  input  logic              bus_rvalidpar,
  input  logic [DATA_W-1:0] bus_rdata,
  input  logic              bus_err,
  input  logic [RCHK_W-1:0] bus_rchk,
  input  logic              integrity_en,
  input  txn_kind_e         head_kind,
  input  logic              head_integrity,
  input  logic              head_gntpar_err,
  output logic              pop,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  output logic              err,
  output logic              integrity_err,
  output logic              parity_fault,
  output logic              data_fault,
  output txn_kind_e         fault_kind
);

  logic [RCHK_W-1:0] rchk_calc;
  logic              gntpar_fault;
  logic              rvalidpar_fault;
  logic              rchk_mismatch;

  // Expected response checksum with exokay tied low
  always_comb begin
    for (int i = 0; i < RCHK_ERR_BIT; i++) begin
      rchk_calc[i] = ^bus_rdata[8*i +: 8];
    end
    rchk_calc[RCHK_ERR_BIT] = ^{bus_err, 1'b0};
  end

  // Parity strobes are checked every cycle
  assign gntpar_fault    = (bus_gntpar == bus_gnt);
  assign rvalidpar_fault = (bus_rvalidpar == bus_rvalid);
  assign parity_fault    = gntpar_fault | rvalidpar_fault;

  // Stores carry no read data so only the err bit counts
  always_comb begin
    if (head_kind == TXN_LOAD) begin
      rchk_mismatch = (bus_rchk != rchk_calc);
    end else begin
      rchk_mismatch = (bus_rchk[RCHK_ERR_BIT] != rchk_calc[RCHK_ERR_BIT]);
    end
  end

  assign pop        = bus_rvalid;
  assign fault_kind = head_kind;
  assign data_fault = bus_rvalid &
                      (head_gntpar_err |
                       rvalidpar_fault |
                       (integrity_en & head_integrity & rchk_mismatch));

  // Response strobe and integrity tag
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rvalid        <= 1'b0;
      integrity_err <= 1'b0;
    end else begin
      rvalid        <= bus_rvalid;
      integrity_err <= data_fault;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (bus_rvalid) begin
      rdata <= bus_rdata;
      err   <= bus_err;
    end
  end

  a_integrity_err_with_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    integrity_err |-> rvalid
  ) else $error("integrity_err raised without a response");

endmodule

// ==== rtl/obi_alert_ctrl.sv ====
// Integrity check enable, major alert pulse and pending NMI
// with its cause code
`timescale 1ns/1ps

module obi_alert_ctrl import obi_integrity_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                cfg_we,
  input  logic                cfg_integrity_en,
  input  logic                parity_fault,
  input  logic                data_fault,
  input  txn_kind_e           fault_kind,
  input  logic                nmi_ack,
  output logic                integrity_en,
  output logic                alert_major,
  output logic                nmi_pending,
  output logic [MCAUSE_W-1:0] mcause
);

  logic [MCAUSE_W-1:0] fault_cause;

  assign fault_cause = (fault_kind == TXN_STORE) ? CAUSE_STORE_INTEGRITY
                                                 : CAUSE_LOAD_INTEGRITY;

  // Checksum checking defaults to on
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      integrity_en <= 1'b1;
    end else if (cfg_we) begin
      integrity_en <= cfg_integrity_en;
    end
  end

  // One cycle pulse per faulty cycle
  // Parity faults count even with checking off
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      alert_major <= 1'b0;
    end else begin
      alert_major <= parity_fault | data_fault;
    end
  end

  // A new fault wins over an ack in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      nmi_pending <= 1'b0;
    end else if (data_fault) begin
      nmi_pending <= 1'b1;
    end else if (nmi_ack) begin
      nmi_pending <= 1'b0;
    end
  end

  // First fault sets the cause, later ones leave it alone
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      mcause <= '0;
    end else if (data_fault && !nmi_pending) begin
      mcause <= fault_cause;
    end
  end

  a_integrity_en_after_reset: assert property (
    @(posedge clk_i)
    $rose(rst_n) |-> integrity_en
  ) else $error("Integrity checking not enabled after reset");

  // Faults seen at the bus must show up on the alert
  a_fault_gives_alert: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    (parity_fault || data_fault) |=> alert_major
  ) else $error("Fault did not raise alert_major");

endmodule

// ==== rtl/obi_integrity_top.sv ====
// Top level of the data-side OBI integrity unit
// Request side, outstanding queue, response checker and alert control
`timescale 1ns/1ps

module obi_integrity_top import obi_integrity_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n,
  // Load/store master
  input  logic                 req,
  input  logic [ADDR_W-1:0]    addr,
  input  logic                 we,
  input  logic [BE_W-1:0]      be,
  input  logic [DATA_W-1:0]    wdata,
  input  logic [PROT_W-1:0]    prot,
  input  logic [MEMTYPE_W-1:0] memtype,
  input  logic                 dbg,
  input  logic                 req_integrity,
  output logic                 gnt,
  output logic                 rvalid,
  output logic [DATA_W-1:0]    rdata,
  output logic                 err,
  output logic                 integrity_err,
  // OBI bus
  output logic                 bus_req,
  output logic                 bus_reqpar,
  output logic [ACHK_W-1:0]    bus_achk,
  output logic [ADDR_W-1:0]    bus_addr,
  output logic                 bus_we,
  output logic [BE_W-1:0]      bus_be,
  output logic [DATA_W-1:0]    bus_wdata,
  output logic [PROT_W-1:0]    bus_prot,
  output logic [MEMTYPE_W-1:0] bus_memtype,
  output logic                 bus_dbg,
  input  logic                 bus_gnt,
  input  logic                 bus_gntpar,
  input  logic                 bus_rvalid,
  input  logic                 bus_rvalidpar,
  input  logic [DATA_W-1:0]    bus_rdata,
  input  logic                 bus_err,
  input  logic [RCHK_W-1:0]    bus_rchk,
  // Configuration
  input  logic                 cfg_we,
  input  logic                 cfg_integrity_en,
  output logic                 integrity_en,
  // Alert and NMI
  output logic                 alert_major,
  output logic                 nmi_pending,
  output logic [MCAUSE_W-1:0]  mcause,
  input  logic                 nmi_ack
);

  logic      queue_full;
  logic      push;
  txn_kind_e push_kind;
  logic      push_integrity;
  logic      push_gntpar_err;
  logic      pop;
  txn_kind_e head_kind;
  logic      head_integrity;
  logic      head_gntpar_err;
  logic      parity_fault;
  logic      data_fault;
  txn_kind_e fault_kind;

  obi_achk_gen u_achk_gen (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .req             (req),
    .addr            (addr),
    .we              (we),
    .be              (be),
    .wdata           (wdata),
    .prot            (prot),
    .memtype         (memtype),
    .dbg             (dbg),
    .req_integrity   (req_integrity),
    .bus_gnt         (bus_gnt),
    .bus_gntpar      (bus_gntpar),
    .queue_full      (queue_full),
    .gnt             (gnt),
    .bus_req         (bus_req),
    .bus_reqpar      (bus_reqpar),
    .bus_achk        (bus_achk),
    .bus_addr        (bus_addr),
    .bus_we          (bus_we),
    .bus_be          (bus_be),
    .bus_wdata       (bus_wdata),
    .bus_prot        (bus_prot),
    .bus_memtype     (bus_memtype),
    .bus_dbg         (bus_dbg),
    .push            (push),
    .push_kind       (push_kind),
    .push_integrity  (push_integrity),
    .push_gntpar_err (push_gntpar_err)
  );

  obi_outstanding_queue u_queue (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .push            (push),
    .push_kind       (push_kind),
    .push_integrity  (push_integrity),
    .push_gntpar_err (push_gntpar_err),
    .pop             (pop),
    .full            (queue_full),
    .head_kind       (head_kind),
    .head_integrity  (head_integrity),
    .head_gntpar_err (head_gntpar_err)
  );

  obi_resp_checker u_resp_checker (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .bus_gnt         (bus_gnt),
    .bus_gntpar      (bus_gntpar),
    .bus_rvalid      (bus_rvalid),
    .bus_rvalidpar   (bus_rvalidpar),
    .bus_rdata       (bus_rdata),
    .bus_err         (bus_err),
    .bus_rchk        (bus_rchk),
    .integrity_en    (integrity_en),
    .head_kind       (head_kind),
    .head_integrity  (head_integrity),
    .head_gntpar_err (head_gntpar_err),
    .pop             (pop),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .err             (err),
    .integrity_err   (integrity_err),
    .parity_fault    (parity_fault),
    .data_fault      (data_fault),
    .fault_kind      (fault_kind)
  );

  obi_alert_ctrl u_alert_ctrl (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .cfg_we           (cfg_we),
    .cfg_integrity_en (cfg_integrity_en),
    .parity_fault     (parity_fault),
    .data_fault       (data_fault),
    .fault_kind       (fault_kind),
    .nmi_ack          (nmi_ack),
    .integrity_en     (integrity_en),
    .alert_major      (alert_major),
    .nmi_pending      (nmi_pending),
    .mcause           (mcause)
  );

endmodule

// ==== testbench/tb_obi_integrity.sv ====
// Testbench for the data-side OBI integrity unit
// Reference model of the outstanding queue, achk/rchk rules,
// checking assertions, stimulus phases and watchdog
`timescale 1ns/1ps

module tb_obi_integrity import obi_integrity_pkg::*; ();

  localparam int NUM_PHASES       = 6;
  localparam int CYCLES_PER_PHASE = 200;

  logic clk_i, rst_n, req, we, dbg, req_integrity, gnt, rvalid, err, integrity_err;
  logic [ADDR_W-1:0] addr, bus_addr;
  logic [BE_W-1:0] be, bus_be;
  logic [DATA_W-1:0] wdata, rdata, bus_wdata, bus_rdata;
  logic [PROT_W-1:0] prot, bus_prot;
  logic [MEMTYPE_W-1:0] memtype, bus_memtype;
  logic bus_req, bus_reqpar, bus_we, bus_dbg, bus_gnt, bus_gntpar;
  logic [ACHK_W-1:0] bus_achk;
  logic bus_rvalid, bus_rvalidpar, bus_err;
  logic [RCHK_W-1:0] bus_rchk;
  logic cfg_we, cfg_integrity_en, integrity_en, alert_major, nmi_pending, nmi_ack;
  logic [MCAUSE_W-1:0] mcause;

  integer seed;
  logic [31:0] rnd;

  // Reference model state
  txn_kind_e m_kind [4];
  logic m_integ [4];
  logic m_gpe [4];
  logic [1:0] m_wr, m_rd, m_cnt;
  logic exp_full, exp_en, exp_nmi, exp_alert_q, exp_interr_q, exp_rvalid_q;
  logic exp_err_q;
  logic exp_gntpar_fault, exp_rvpar_fault, exp_rchk_bad, exp_data_fault;
  logic [RCHK_W-1:0] exp_rchk;
  logic [DATA_W-1:0] exp_rdata_q;
  logic [MCAUSE_W-1:0] exp_cause, exp_mcause;

  obi_integrity_top UUT (.*);

  function automatic logic [ACHK_W-1:0] achk_ref(
    input logic [ADDR_W-1:0] a, input logic w, input logic [BE_W-1:0] b,
    input logic [DATA_W-1:0] d, input logic [PROT_W-1:0] p,
    input logic [MEMTYPE_W-1:0] m, input logic g);
    logic [ACHK_W-1:0] c;
    c[0] = ^a[7:0];
    c[1] = ^a[15:8];
    c[2] = ^a[23:16];
    c[3] = ^a[31:24];
    c[4] = ~(^p ^ ^m);
    c[5] = ~(^b ^ w);
    c[6] = ~g;
    c[7] = 1'b0;
    c[8] = ^d[7:0];
    c[9] = ^d[15:8];
    c[10] = ^d[23:16];
    c[11] = ^d[31:24];
    return c;
  endfunction

  function automatic logic [RCHK_W-1:0] rchk_ref(input logic [DATA_W-1:0] d, input logic e);
    logic [RCHK_W-1:0] c;
    c[0] = ^d[7:0];
    c[1] = ^d[15:8];
    c[2] = ^d[23:16];
    c[3] = ^d[31:24];
    c[4] = e;
    return c;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    abort_run($sformatf("[ERROR] %0t %s expected 0x%0h actual 0x%0h",
                        $time, name, exp_val, act_val));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Expected fault and response terms
  assign m_cnt            = m_wr - m_rd;
  assign exp_full         = (m_cnt == 2'd2);
  assign exp_gntpar_fault = (bus_gntpar == bus_gnt);
  assign exp_rvpar_fault  = (bus_rvalidpar == bus_rvalid);
  assign exp_rchk         = rchk_ref(bus_rdata, bus_err);
  assign exp_rchk_bad     = (m_kind[m_rd] == TXN_LOAD) ? (bus_rchk != exp_rchk)
                          : (bus_rchk[RCHK_ERR_BIT] != exp_rchk[RCHK_ERR_BIT]);
  assign exp_data_fault   = bus_rvalid & (m_gpe[m_rd] | exp_rvpar_fault |
                                          (exp_en & m_integ[m_rd] & exp_rchk_bad));
  assign exp_cause        = (m_kind[m_rd] == TXN_STORE) ? CAUSE_STORE_INTEGRITY
                                                        : CAUSE_LOAD_INTEGRITY;

  always @(posedge clk_i) begin
    if (!rst_n) begin
      m_wr <= 2'd0;
      m_rd <= 2'd0;
      exp_en <= 1'b1;
      exp_nmi <= 1'b0;
      exp_mcause <= '0;
      exp_alert_q <= 1'b0;
      exp_interr_q <= 1'b0;
      exp_rvalid_q <= 1'b0;
    end else begin
      if (req && bus_gnt && !exp_full) begin
        m_kind[m_wr] <= we ? TXN_STORE : TXN_LOAD;
        m_integ[m_wr] <= req_integrity;
        m_gpe[m_wr] <= exp_gntpar_fault;
        m_wr <= m_wr + 2'd1;
      end
      if (bus_rvalid) begin
        m_rd <= m_rd + 2'd1;
        exp_rdata_q <= bus_rdata;
        exp_err_q <= bus_err;
      end
      if (cfg_we) begin
        exp_en <= cfg_integrity_en;
      end
      if (exp_data_fault) begin
        exp_nmi <= 1'b1;
      end else if (nmi_ack) begin
        exp_nmi <= 1'b0;
      end
      if (exp_data_fault && !exp_nmi) begin
        exp_mcause <= exp_cause;
      end
      exp_alert_q <= exp_gntpar_fault | exp_rvpar_fault | exp_data_fault;
      exp_interr_q <= exp_data_fault;
      exp_rvalid_q <= bus_rvalid;
    end
  end

  a_reqpar: assert property (@(posedge clk_i) disable iff (!rst_n) bus_reqpar == !bus_req)
    else report_mismatch("bus_reqpar", 32'(!$sampled(bus_req)), 32'($sampled(bus_reqpar)));
  a_achk: assert property (@(posedge clk_i) disable iff (!rst_n)
    bus_req |-> bus_achk == achk_ref(addr, we, be, wdata, prot, memtype, dbg))
    else report_mismatch("bus_achk", 32'(achk_ref($sampled(addr), $sampled(we), $sampled(be),
      $sampled(wdata), $sampled(prot), $sampled(memtype), $sampled(dbg))),
      32'($sampled(bus_achk)));
  // Request fields go straight through to the bus
  a_bus_addr: assert property (@(posedge clk_i) disable iff (!rst_n) bus_addr == addr)
    else report_mismatch("bus_addr", $sampled(addr), $sampled(bus_addr));
  a_bus_wdata: assert property (@(posedge clk_i) disable iff (!rst_n) bus_wdata == wdata)
    else report_mismatch("bus_wdata", $sampled(wdata), $sampled(bus_wdata));
  a_bus_we: assert property (@(posedge clk_i) disable iff (!rst_n) bus_we == we)
    else report_mismatch("bus_we", 32'($sampled(we)), 32'($sampled(bus_we)));
  a_bus_be: assert property (@(posedge clk_i) disable iff (!rst_n) bus_be == be)
    else report_mismatch("bus_be", 32'($sampled(be)), 32'($sampled(bus_be)));
  a_bus_prot: assert property (@(posedge clk_i) disable iff (!rst_n) bus_prot == prot)
    else report_mismatch("bus_prot", 32'($sampled(prot)), 32'($sampled(bus_prot)));
  a_bus_memtype: assert property (@(posedge clk_i) disable iff (!rst_n) bus_memtype == memtype)
    else report_mismatch("bus_memtype", 32'($sampled(memtype)), 32'($sampled(bus_memtype)));
  a_bus_dbg: assert property (@(posedge clk_i) disable iff (!rst_n) bus_dbg == dbg)
    else report_mismatch("bus_dbg", 32'($sampled(dbg)), 32'($sampled(bus_dbg)));
  // Back-pressure while two transactions are outstanding
  a_bus_req: assert property (@(posedge clk_i) disable iff (!rst_n)
    bus_req == (req && !exp_full))
    else report_mismatch("bus_req", 32'($sampled(req && !exp_full)), 32'($sampled(bus_req)));
  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n) gnt == (bus_gnt && !exp_full))
    else report_mismatch("gnt", 32'($sampled(bus_gnt && !exp_full)), 32'($sampled(gnt)));
  a_alert: assert property (@(posedge clk_i) disable iff (!rst_n) alert_major == exp_alert_q)
    else report_mismatch("alert_major", 32'($sampled(exp_alert_q)),
                         32'($sampled(alert_major)));
  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n) rvalid == exp_rvalid_q)
    else report_mismatch("rvalid", 32'($sampled(exp_rvalid_q)), 32'($sampled(rvalid)));
  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n) rvalid |-> rdata == exp_rdata_q)
    else report_mismatch("rdata", $sampled(exp_rdata_q), $sampled(rdata));
  a_err: assert property (@(posedge clk_i) disable iff (!rst_n) rvalid |-> err == exp_err_q)
    else report_mismatch("err", 32'($sampled(exp_err_q)), 32'($sampled(err)));
  a_integrity_err: assert property (@(posedge clk_i) disable iff (!rst_n)
    integrity_err == exp_interr_q)
    else report_mismatch("integrity_err", 32'($sampled(exp_interr_q)),
                         32'($sampled(integrity_err)));
  a_nmi: assert property (@(posedge clk_i) disable iff (!rst_n) nmi_pending == exp_nmi)
    else report_mismatch("nmi_pending", 32'($sampled(exp_nmi)), 32'($sampled(nmi_pending)));
  a_mcause: assert property (@(posedge clk_i) disable iff (!rst_n)
    nmi_pending |-> mcause == exp_mcause)
    else report_mismatch("mcause", 32'($sampled(exp_mcause)), 32'($sampled(mcause)));
  a_en: assert property (@(posedge clk_i) disable iff (!rst_n) integrity_en == exp_en)
    else report_mismatch("integrity_en", 32'($sampled(exp_en)), 32'($sampled(integrity_en)));
  a_en_after_reset: assert property (@(posedge clk_i) $rose(rst_n) |-> integrity_en)
    else report_mismatch("integrity_en", 32'd1, 32'($sampled(integrity_en)));

  // Hold one request until the DUT grants it
  task automatic drive_request(input logic wr, input logic bad_gntpar);
    logic [31:0] r;
    @(negedge clk_i);
    r = $random(seed);
    addr = r;
    r = $random(seed);
    wdata = r;
    r = $random(seed);
    be = r[3:0];
    prot = r[6:4];
    memtype = r[8:7];
    dbg = r[9];
    we = wr;
    req_integrity = 1'b1;
    req = 1'b1;
    bus_gnt = 1'b1;
    bus_gntpar = bad_gntpar;
    #1;
    while (!gnt) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req = 1'b0;
    bus_gnt = 1'b0;
    bus_gntpar = 1'b1;
  endtask

  task automatic drive_response(input logic [RCHK_W-1:0] rchk_flip, input logic bad_rvpar);
    logic [31:0] r;
    r = $random(seed);
    @(negedge clk_i);
    bus_rvalid = 1'b1;
    bus_rvalidpar = bad_rvpar;
    bus_rdata = r;
    bus_err = r[31];
    bus_rchk = rchk_ref(r, r[31]) ^ rchk_flip;
    @(negedge clk_i);
    bus_rvalid = 1'b0;
    bus_rvalidpar = 1'b1;
  endtask

  task automatic ack_nmi();
    repeat (2) @(negedge clk_i);
    nmi_ack = 1'b1;
    @(negedge clk_i);
    nmi_ack = 1'b0;
  endtask

  task automatic write_enable(input logic en);
    @(negedge clk_i);
    cfg_we = 1'b1;
    cfg_integrity_en = en;
    @(negedge clk_i);
    cfg_we = 1'b0;
  endtask

  initial begin
    repeat (NUM_PHASES * CYCLES_PER_PHASE) @(posedge clk_i);
    abort_run("Watchdog timeout: the test phases did not complete in time");
  end

  initial begin
    seed = 9;
    {req, we, dbg, req_integrity, addr, be, wdata, prot, memtype} = '0;
    {bus_gnt, bus_rvalid, bus_rdata, bus_err, bus_rchk} = '0;
    bus_gntpar = 1'b1;
    bus_rvalidpar = 1'b1;
    {cfg_we, nmi_ack} = '0;
    cfg_integrity_en = 1'b1;
    rst_n = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n = 1'b1;
    // Random clean traffic
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      drive_request(rnd[0], 1'b0);
      drive_response('0, 1'b0);
    end
    // Grant parity fault is carried to the response
    drive_request(1'b0, 1'b1);
    drive_response('0, 1'b0);
    ack_nmi();
    // rvalid parity fault on a load
    drive_request(1'b0, 1'b0);
    drive_response('0, 1'b1);
    ack_nmi();
    // rchk mismatches by transaction kind
    drive_request(1'b0, 1'b0);
    drive_response(5'b00001, 1'b0);
    ack_nmi();
    drive_request(1'b1, 1'b0);
    drive_response(5'b10000, 1'b0);
    ack_nmi();
    drive_request(1'b1, 1'b0);
    drive_response(5'b00110, 1'b0);
    // Checking switched off
    write_enable(1'b0);
    drive_request(1'b0, 1'b0);
    drive_response(5'b01001, 1'b0);
    write_enable(1'b1);
    // Third request waits for a response
    drive_request(1'b0, 1'b0);
    drive_request(1'b1, 1'b0);
    fork
      drive_request(1'b0, 1'b0);
      begin
        repeat (4) @(negedge clk_i);
        drive_response('0, 1'b0);
      end
    join
    drive_response('0, 1'b0);
    drive_response('0, 1'b0);
    repeat (3) @(negedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== src.f ====
rtl/obi_integrity_pkg.sv
rtl/obi_achk_gen.sv
rtl/obi_outstanding_queue.sv
rtl/obi_resp_checker.sv
rtl/obi_alert_ctrl.sv
rtl/obi_integrity_top.sv
testbench/tb_obi_integrity.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the OBI integrity testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module tb_obi_integrity \
  -o tb_obi_integrity
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/tb_obi_integrity
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0
